// ==== hw/neuron_pkg.sv ====
package neuron_pkg;

    // membrane potentials are unsigned and wrap modulo 2^32.
    typedef logic [31:0] potential_t;

    typedef enum logic [2:0] {
        mode_lif0  = 3'd0,
        mode_lif2  = 3'd1,
        mode_lif4  = 3'd2,
        mode_lif8  = 3'd3,
        mode_lif24 = 3'd4,
        mode_izhi  = 3'd5,
        mode_quad  = 3'd6,
        mode_idle  = 3'd7
    } decay_mode_e;

    // encoding 2'b11 is reserved and decodes as a nop.
    typedef enum logic [1:0] {
        op_nop    = 2'd0,
        op_load   = 2'd1,
        op_config = 2'd2
    } cmd_op_e;

    typedef struct packed {
        decay_mode_e mode;      // top three bits of the payload.
        logic [28:0] threshold; // zero-extended before the compare.
    } neuron_config_t;

    // the opcode selects which view of the command word is read.
    typedef union packed {
        potential_t     value;
        neuron_config_t cfg;
    } cmd_payload_u;

    // largest threshold the config word can express.
    localparam potential_t default_threshold = 32'h1fff_ffff;

endpackage

// ==== hw/neuron_decode.sv ====
`timescale 1ns/100ps

module neuron_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  neuron_pkg::cmd_op_e     cmd_op,
    input  neuron_pkg::cmd_payload_u cmd_payload,
    input  logic                    busy,
    output logic                    load_strobe,
    output neuron_pkg::potential_t  load_value,
    output neuron_pkg::decay_mode_e mode,
    output neuron_pkg::potential_t  threshold
);
    import neuron_pkg::*;

    logic accept;

    assign accept = cmd_valid && !busy; // commands during an update are dropped.

    always_ff @(posedge clk) begin
        if (rst) begin
            load_strobe <= 1'b0;
            mode        <= mode_idle;
            threshold   <= default_threshold;
        end else begin
            load_strobe <= 1'b0;
            if (accept) begin
                case (cmd_op)
                    op_load: begin
                        load_strobe <= 1'b1;
                    end
                    op_config: begin
                        mode      <= cmd_payload.cfg.mode;
                        threshold <= {3'b000, cmd_payload.cfg.threshold};
                    end
                    default: begin
                        // nop and the reserved encoding leave all state alone.
                    end
                endcase
            end
        end
    end

    // the value rides along with the strobe and is only used while it is high.
    always_ff @(posedge clk) begin
        if (accept && cmd_op == op_load) begin
            load_value <= cmd_payload.value;
        end
    end

    // each load is a single strobe, so a new one never lands on the previous one.
    a_load_single : assert property (
        @(posedge clk) disable iff (rst)
        load_strobe |=> !load_strobe
    ) else $error("load_strobe high on two consecutive cycles");

endmodule

// ==== hw/seq_multiplier.sv ====
`timescale 1ns/100ps

module seq_multiplier (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mul_start,
    input  neuron_pkg::potential_t mul_a,
    input  neuron_pkg::potential_t mul_b,
    output neuron_pkg::potential_t mul_product,
    output logic                   mul_done
);
    import neuron_pkg::*;

    logic       running;
    logic [4:0] count;
    potential_t acc;
    potential_t mcand;
    potential_t mplier;

    assign mul_product = acc; // stable from mul_done until the next start.

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            count    <= 5'd0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                running <= 1'b1;
                count   <= 5'd0;
            end else if (running) begin
                count <= count + 5'd1;
                if (count == 5'd31) begin
                    running  <= 1'b0; // last multiplier bit done.
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // each cycle handles one multiplier bit while the multiplicand moves left.
    // bits shifted past 31 are lost, which leaves the low product word.
    always_ff @(posedge clk) begin
        if (mul_start) begin
            acc    <= '0;
            mcand  <= mul_a;
            mplier <= mul_b;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_no_restart : assert property (
        @(posedge clk) disable iff (rst)
        mul_start |-> !running
    ) else $error("mul_start while a multiply is still running");

endmodule

// ==== hw/decay_execute.sv ====
`timescale 1ns/100ps

module decay_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    step,
    input  neuron_pkg::decay_mode_e mode,
    input  neuron_pkg::potential_t  potential,
    input  neuron_pkg::potential_t  mul_product,
    input  logic                    mul_done,
    output logic                    busy,
    output logic                    exec_done,
    output neuron_pkg::potential_t  next_potential,
    output logic                    mul_start,
    output neuron_pkg::potential_t  mul_a,
    output neuron_pkg::potential_t  mul_b
);
    import neuron_pkg::*;

    logic        accept;
    logic        wait_mul;
    potential_t  v_q;
    decay_mode_e mode_q;
    potential_t  five_v;

    function automatic logic uses_mul(input decay_mode_e m);
        return (m == mode_izhi) || (m == mode_quad);
    endfunction

    assign accept = step && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            exec_done <= 1'b0;
            mul_start <= 1'b0;
            wait_mul  <= 1'b0;
        end else begin
            exec_done <= 1'b0;
            mul_start <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                if (uses_mul(mode)) begin
                    mul_start <= 1'b1;
                    wait_mul  <= 1'b1;
                end else begin
                    exec_done <= 1'b1; // shift and hold modes finish at once.
                end
            end else if (exec_done) begin
                busy <= 1'b0; // falls on the writeback edge.
            end else if (wait_mul && mul_done) begin
                wait_mul  <= 1'b0;
                exec_done <= 1'b1;
            end
        end
    end

    // operands are frozen for the whole update so a load cannot disturb them.
    always_ff @(posedge clk) begin
        if (accept) begin
            v_q    <= potential;
            mode_q <= mode;
        end
    end

    assign mul_a  = v_q;
    assign mul_b  = v_q;
    assign five_v = (v_q << 2) + v_q;

    always_comb begin
        case (mode_q)
            mode_lif2:  next_potential = v_q >> 1;
            mode_lif4:  next_potential = v_q >> 2;
            mode_lif8:  next_potential = v_q >> 3;
            mode_lif24: next_potential = (v_q >> 1) + (v_q >> 2);
            mode_izhi:  next_potential = (mul_product >> 3) - five_v; // may wrap below zero.
            mode_quad:  next_potential = mul_product;
            default:    next_potential = v_q; // lif0 and idle hold.
        endcase
    end

    a_done_in_busy : assert property (
        @(posedge clk) disable iff (rst)
        exec_done |-> busy
    ) else $error("exec_done outside of a busy window");

endmodule

// ==== hw/spike_result.sv ====
`timescale 1ns/100ps

module spike_result #(
    parameter logic [31:0] RESET_POTENTIAL = 32'h0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_strobe,
    input  neuron_pkg::potential_t load_value,
    input  logic                   exec_done,
    input  neuron_pkg::potential_t next_potential,
    input  neuron_pkg::potential_t threshold,
    output neuron_pkg::potential_t potential,
    output logic                   spike
);
    import neuron_pkg::*;

    logic fire;

    assign fire = next_potential >= threshold; // at or above counts as a spike.

    always_ff @(posedge clk) begin
        if (rst) begin
            potential <= '0;
            spike     <= 1'b0;
        end else begin
            spike <= 1'b0;
            if (load_strobe) begin
                potential <= load_value;
            end else if (exec_done) begin
                if (fire) begin
                    potential <= potential_t'(RESET_POTENTIAL);
                    spike     <= 1'b1;
                end else begin
                    potential <= next_potential;
                end
            end
        end
    end

    // decode only loads while execute is idle, so the two writers never meet.
    a_one_writer : assert property (
        @(posedge clk) disable iff (rst)
        !(load_strobe && exec_done)
    ) else $error("load and writeback in the same cycle");

endmodule

// ==== hw/neuron_top.sv ====
`timescale 1ns/100ps

module neuron_top #(
    parameter logic [31:0] RESET_POTENTIAL = 32'h0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid,
    input  neuron_pkg::cmd_op_e      cmd_op,
    input  neuron_pkg::cmd_payload_u cmd_payload,
    input  logic                     step,
    output neuron_pkg::potential_t   potential,
    output logic                     spike,
    output logic                     busy
);
    import neuron_pkg::*;

    logic        load_strobe;
    potential_t  load_value;
    decay_mode_e mode;
    potential_t  threshold;
    logic        exec_done;
    potential_t  next_potential;
    logic        mul_start;
    potential_t  mul_a;
    potential_t  mul_b;
    potential_t  mul_product;
    logic        mul_done;

    neuron_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_payload (cmd_payload),
        .busy        (busy),
        .load_strobe (load_strobe),
        .load_value  (load_value),
        .mode        (mode),
        .threshold   (threshold)
    );

    decay_execute u_execute (
        .clk            (clk),
        .rst            (rst),
        .step           (step),
        .mode           (mode),
        .potential      (potential),
        .mul_product    (mul_product),
        .mul_done       (mul_done),
        .busy           (busy),
        .exec_done      (exec_done),
        .next_potential (next_potential),
        .mul_start      (mul_start),
        .mul_a          (mul_a),
        .mul_b          (mul_b)
    );

    seq_multiplier u_mul (
        .clk         (clk),
        .rst         (rst),
        .mul_start   (mul_start),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_product (mul_product),
        .mul_done    (mul_done)
    );

    spike_result #(
        .RESET_POTENTIAL (RESET_POTENTIAL)
    ) u_result (
        .clk            (clk),
        .rst            (rst),
        .load_strobe    (load_strobe),
        .load_value     (load_value),
        .exec_done      (exec_done),
        .next_potential (next_potential),
        .threshold      (threshold),
        .potential      (potential),
        .spike          (spike)
    );

endmodule

// ==== tb/neuron_tb.sv ====
`timescale 1ns/100ps

module neuron_tb;
    import neuron_pkg::*;

    localparam logic [63:0] act_load     = 64'("load");
    localparam logic [63:0] act_nop      = 64'("nop");
    localparam logic [63:0] act_config   = 64'("config");
    localparam logic [63:0] act_step     = 64'("step");
    localparam logic [63:0] act_stepbusy = 64'("stepbusy");
    localparam logic [63:0] act_comment  = 64'("#");

    logic         clk;
    logic         rst;
    logic         cmd_valid;
    cmd_op_e      cmd_op;
    cmd_payload_u cmd_payload;
    logic         step;
    potential_t   potential;
    logic         spike;
    logic         busy;

    logic [63:0] vec_action [$];
    potential_t  vec_payload [$];
    potential_t  vec_potential [$];
    logic        vec_spike [$];

    int errors = 0;
    int vec_errors = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;
    int cycle_limit = 0;
    logic vectors_ok;
    potential_t last_exp = '0;

    neuron_top #(
        .RESET_POTENTIAL (32'h10)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_payload (cmd_payload),
        .step        (step),
        .potential   (potential),
        .spike       (spike),
        .busy        (busy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, busy never dropped", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic string action_name(input logic [63:0] act);
        case (act)
            act_load:     return "load";
            act_nop:      return "nop";
            act_config:   return "config";
            act_step:     return "step";
            act_stepbusy: return "stepbusy";
            default:      return "unknown";
        endcase
    endfunction

    task automatic read_vectors(output logic ok);
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [63:0]      act;
        potential_t       pay;
        potential_t       exp_pot;
        logic             exp_spk;
        fd = $fopen("tb/neuron_vectors.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            line = '0;
            while ($fgets(line, fd) != 0) begin
                act = '0;
                n = $sscanf(line, "%s %h %h %h", act, pay, exp_pot, exp_spk);
                if (n == 4 && act != act_comment) begin // blank and comment lines fall out here.
                    vec_action.push_back(act);
                    vec_payload.push_back(pay);
                    vec_potential.push_back(exp_pot);
                    vec_spike.push_back(exp_spk);
                end
                line = '0;
            end
            $fclose(fd);
        end
    endtask

    task automatic check_potential(input potential_t got, input potential_t exp);
        if (got !== exp) begin
            $display("[ERROR] potential got %h expected %h", got, exp);
            vec_errors++;
        end
    endtask

    task automatic check_spike(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] spike got %h expected %h", got, exp);
            vec_errors++;
        end
    endtask

    // a command shows at the potential output two edges after it is driven.
    task automatic send_cmd(input cmd_op_e op, input potential_t pay);
        @(posedge clk);
        cmd_valid   <= 1'b1;
        cmd_op      <= op;
        cmd_payload <= pay;
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_op    <= op_nop;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_step(input logic interfere, input potential_t pay,
                            input potential_t held);
        @(posedge clk);
        step <= 1'b1;
        @(posedge clk);
        step <= 1'b0;
        @(negedge clk);
        if (!busy) begin
            $display("busy did not rise after a step pulse");
            vec_errors++;
        end else begin
            if (interfere) begin
                @(posedge clk);
                cmd_valid   <= 1'b1; // both should be dropped while busy is high.
                cmd_op      <= op_load;
                cmd_payload <= pay;
                step        <= 1'b1;
                @(posedge clk);
                cmd_valid <= 1'b0;
                cmd_op    <= op_nop;
                step      <= 1'b0;
                @(negedge clk);
                @(negedge clk);
                if (busy) begin
                    check_potential(potential, held); // an accepted load would show by now.
                end
            end
            while (busy) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic confirm_idle();
        repeat (2) @(negedge clk);
        if (busy) begin
            $display("a step sent during busy started a second update");
            vec_errors++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        cmd_valid   = 1'b0;
        cmd_op      = op_nop;
        cmd_payload = '0;
        step        = 1'b0;
        read_vectors(vectors_ok);
        if (!vectors_ok) begin
            $display("could not open tb/neuron_vectors.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            cycle_limit = 40 * vec_action.size() + 100;
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < vec_action.size(); i++) begin
                vec_errors = 0;
                case (vec_action[i])
                    act_load:     send_cmd(op_load, vec_payload[i]);
                    act_nop:      send_cmd(op_nop, vec_payload[i]);
                    act_config:   send_cmd(op_config, vec_payload[i]);
                    act_step:     run_step(1'b0, vec_payload[i], last_exp);
                    act_stepbusy: run_step(1'b1, vec_payload[i], last_exp);
                    default: begin
                        $display("vector %0d has an action that is not known", i);
                        vec_errors++;
                    end
                endcase
                check_potential(potential, vec_potential[i]);
                check_spike(spike, vec_spike[i]);
                if (vec_action[i] == act_stepbusy) begin
                    confirm_idle();
                end
                if (vec_errors == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
                errors += vec_errors;
                last_exp = vec_potential[i];
                $display("vector %0d %s %h -> %h spike %h : %s", i,
                    action_name(vec_action[i]), vec_payload[i], potential, spike,
                    (vec_errors == 0) ? "ok" : "mismatch");
            end
            $display("vectors %0d, passed %0d, failed %0d, errors %0d",
                vec_action.size(), passed, failed, errors);
            if (errors == 0 && vec_action.size() > 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== tb/neuron_vectors.txt ====
# action payload expected_potential expected_spike, all in hex
# stepbusy also sends a load of its payload and a second step while busy is high
load     00001234 00001234 0
nop      deadbeef 00001234 0
config   3fffffff 00001234 0
step     00000000 0000091a 0
step     00000000 0000048d 0
load     01000000 01000000 0
config   5fffffff 01000000 0
step     00000000 00400000 0
config   7fffffff 00400000 0
step     00000000 00080000 0
config   9fffffff 00080000 0
load     00001000 00001000 0
step     00000000 00000c00 0
step     00000000 00000900 0
config   1fffffff 00000900 0
step     00000000 00000900 0
config   ffffffff 00000900 0
step     00000000 00000900 0
config   dfffffff 00000900 0
load     00001000 00001000 0
step     00000000 01000000 0
load     00010001 00010001 0
step     00000000 00020001 0
config   bfffffff 00020001 0
load     00000100 00000100 0
step     00000000 00001b00 0
step     00000000 005a9900 0
load     00000010 00000010 0
step     00000000 00000010 1
config   20000100 00000010 0
load     00000200 00000200 0
step     00000000 00000010 1
load     000001fe 000001fe 0
step     00000000 000000ff 0
config   dfffffff 000000ff 0
load     00000100 00000100 0
stepbusy 00abcdef 00010000 0
nop      00000000 00010000 0

// ==== sim.f ====
hw/neuron_pkg.sv
hw/neuron_decode.sv
hw/seq_multiplier.sv
hw/decay_execute.sv
hw/spike_result.sv
hw/neuron_top.sv
tb/neuron_tb.sv

// ==== Makefile ====
# Verilator build and run for the neuron testbench.

VERILATOR ?= verilator
TOP       ?= neuron_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR=$(VERILATOR) TOP=$(TOP) LOG=$(LOG) OBJ_DIR=$(OBJ_DIR)"

test:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
